// ==== project.f ====
+incdir+.
multiplierPkg.sv
partialProductGen.sv
carrySaveArray.sv
carryPropagate.sv
arrayMultiplier.sv
arrayMultiplier_assert.sv
arrayMultiplier_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= arrayMultiplier_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing -j 0

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) multiplier_defines.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== arrayMultiplier_tb.sv ====
`include "multiplier_defines.svh"

module arrayMultiplier_tb;

        import multiplierPkg::*;

        localparam int NUM_TRANS   = 600;
        localparam int CYCLE_LIMIT = NUM_TRANS * 4 + 200;
        localparam int RANDOM_SEED = 32'h35d6;

        logic     clk = 1'b0;
        logic     reset;
        logic     inValid;
        logic     inReady;
        operand_t multiplicand;
        operand_t multiplier;
        logic     isSigned;
        logic     outValid;
        logic     outReady;
        product_t product;

        product_t expQ [$];
        product_t expected;
        logic     stallMode;
        int       sent;
        int       received;
        int       cycleCount;

        arrayMultiplier u_dut (
                .clk          (clk),
                .reset        (reset),
                .inValid      (inValid),
                .inReady      (inReady),
                .multiplicand (multiplicand),
                .multiplier   (multiplier),
                .isSigned     (isSigned),
                .outValid     (outValid),
                .outReady     (outReady),
                .product      (product)
        );

        always #10 clk = ~clk;

        ////////////////////////////////////////////////////////////////////////////
        // reference and checks
        ////////////////////////////////////////////////////////////////////////////

        // plain integer product, sign or zero extended by mode.
        function automatic product_t mulRef(input operand_t a, input operand_t b, input logic s);
                longint ea;
                longint eb;
                if (s) begin
                        ea = longint'($signed(a));
                        eb = longint'($signed(b));
                end else begin
                        ea = longint'(a);
                        eb = longint'(b);
                end
                return product_t'(ea * eb);
        endfunction

        task automatic abortRun();
                $display(">>> FAIL");
                $fatal(1);
        endtask

        task automatic checkProduct(input string name, input product_t got, input product_t exp);
                if (got !== exp) begin
                        $display("FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
                        abortRun();
                end
        endtask

        task automatic checkFlag(input string name, input logic got, input logic exp);
                if (got !== exp) begin
                        $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
                        abortRun();
                end
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // stimulus
        ////////////////////////////////////////////////////////////////////////////

        // holds the operands until the stage takes them.
        task automatic sendOp(input operand_t a, input operand_t b, input logic s);
                @(negedge clk);
                inValid      = 1'b1;
                multiplicand = a;
                multiplier   = b;
                isSigned     = s;
                @(posedge clk);
                while (!inReady) begin
                        if (!stallMode) begin
                                $display("inReady was low although outReady was held high");
                                abortRun();
                        end
                        @(posedge clk);
                end
                expQ.push_back(mulRef(a, b, s));
                sent++;
        endtask

        task automatic sendRandom();
                sendOp(operand_t'($urandom), operand_t'($urandom), ($urandom % 2) == 1);
        endtask

        task automatic idleCycle();
                @(negedge clk);
                inValid      = 1'b0;
                multiplicand = operand_t'($urandom);
                multiplier   = operand_t'($urandom);
        endtask

        // back-pressure only in the last phase.
        always @(negedge clk) begin
                if (stallMode) begin
                        outReady = ($urandom % 4) != 0;
                end else begin
                        outReady = 1'b1;
                end
        end

        initial begin
                void'($urandom(RANDOM_SEED));
                reset        = 1'b1;
                inValid      = 1'b0;
                multiplicand = '0;
                multiplier   = '0;
                isSigned     = 1'b0;
                outReady     = 1'b1;
                stallMode    = 1'b0;
                sent         = 0;
                repeat (8) @(negedge clk);
                reset = 1'b0;
                @(posedge clk);
                checkFlag("outValid", outValid, 1'b0);
                checkFlag("inReady", inReady, 1'b1);

                // known corner products.
                checkProduct("mulRef", mulRef(16'hFFFF, 16'hFFFF, 1'b0), 32'hFFFE0001);
                checkProduct("mulRef", mulRef(16'h8000, 16'h8000, 1'b1), 32'h40000000);
                checkProduct("mulRef", mulRef(16'hFFFF, 16'h0001, 1'b1), 32'hFFFFFFFF);
                checkProduct("mulRef", mulRef(16'h8000, 16'h7FFF, 1'b1), 32'hC0008000);

                sendOp(16'h0000, 16'h0000, 1'b0);
                sendOp(16'h0000, 16'hFFFF, 1'b0);
                sendOp(16'h0001, 16'h1234, 1'b0);
                sendOp(16'hFFFF, 16'h0001, 1'b0);
                sendOp(16'hFFFF, 16'hFFFF, 1'b0);
                for (int i = 0; i < `OPERAND_WIDTH; i++) begin
                        sendOp(operand_t'(1) << i, operand_t'(1) << (`OPERAND_WIDTH - 1 - i), 1'b0);
                end
                sendOp(16'h8000, 16'h8000, 1'b1);
                sendOp(16'hFFFF, 16'h0001, 1'b1);
                sendOp(16'h8000, 16'h7FFF, 1'b1);
                sendOp(16'h7FFF, 16'h7FFF, 1'b1);
                sendOp(16'hFFFF, 16'hFFFF, 1'b1);

                // full rate, then with gaps and random stalls.
                while (sent < NUM_TRANS / 2) begin
                        sendRandom();
                end
                stallMode = 1'b1;
                while (sent < NUM_TRANS) begin
                        if (($urandom % 5) == 0) begin
                                idleCycle();
                        end
                        sendRandom();
                end
                idleCycle();

                while (received < NUM_TRANS) begin
                        @(posedge clk);
                end
                repeat (6) @(posedge clk);
                if (expQ.size() != 0 || received != NUM_TRANS) begin
                        $display("run ended with %0d products missing", expQ.size());
                        abortRun();
                end else begin
                        $display(">>> PASS");
                        $finish;
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // compare and watchdog
        ////////////////////////////////////////////////////////////////////////////

        initial received = 0;

        always @(posedge clk) begin
                if (!reset && outValid && outReady) begin
                        if (expQ.size() == 0) begin
                                $display("a product came out with no input waiting for it");
                                abortRun();
                        end else begin
                                expected = expQ.pop_front();
                                checkProduct("product", product, expected);
                                received++;
                        end
                end
        end

        initial cycleCount = 0;

        always @(posedge clk) begin
                cycleCount++;
                if (cycleCount >= CYCLE_LIMIT) begin
                        $display("timed out after %0d cycles with %0d of %0d products received",
                                 cycleCount, received, NUM_TRANS);
                        abortRun();
                end
        end

endmodule

// ==== arrayMultiplier_assert.sv ====
module arrayMultiplier_assert (
        input logic                    clk,
        input logic                    reset,
        input logic                    inReady,
        input logic                    outValid,
        input logic                    outReady,
        input multiplierPkg::product_t product
);

        // a stalled result must not move.
        holdResult: assert property (@(posedge clk) disable iff (reset)
                outValid && !outReady |=> outValid && $stable(product))
                else $error("result changed while waiting for outReady");

        validCleared: assert property (@(posedge clk) reset |=> !outValid)
                else $error("outValid high in the cycle after reset");

        readyKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(inReady))
                else $error("inReady is unknown");

endmodule

bind arrayMultiplier arrayMultiplier_assert u_assert (
        .clk      (clk),
        .reset    (reset),
        .inReady  (inReady),
        .outValid (outValid),
        .outReady (outReady),
        .product  (product)
);

// ==== arrayMultiplier.sv ====
`include "multiplier_defines.svh"

module arrayMultiplier (
        input  logic                    clk,
        input  logic                    reset,
        input  logic                    inValid,
        output logic                    inReady,
        input  multiplierPkg::operand_t multiplicand,
        input  multiplierPkg::operand_t multiplier,
        input  logic                    isSigned,
        output logic                    outValid,
        input  logic                    outReady,
        output multiplierPkg::product_t product
);

        import multiplierPkg::*;

        // decode to execute.
        logic     ppValid;
        logic     ppReady;
        ppRow_t   ppRows [`PP_ROWS];

        // execute to result.
        logic     csaValid;
        logic     csaReady;
        csaWord_t csaSum;
        csaWord_t csaCarry;

        partialProductGen u_partialProductGen (
                .clk          (clk),
                .reset        (reset),
                .inValid      (inValid),
                .inReady      (inReady),
                .multiplicand (multiplicand),
                .multiplier   (multiplier),
                .isSigned     (isSigned),
                .ppValid      (ppValid),
                .ppReady      (ppReady),
                .ppRows       (ppRows)
        );

        carrySaveArray u_carrySaveArray (
                .clk      (clk),
                .reset    (reset),
                .ppValid  (ppValid),
                .ppReady  (ppReady),
                .ppRows   (ppRows),
                .csaValid (csaValid),
                .csaReady (csaReady),
                .csaSum   (csaSum),
                .csaCarry (csaCarry)
        );

        carryPropagate u_carryPropagate (
                .clk      (clk),
                .reset    (reset),
                .csaValid (csaValid),
                .csaReady (csaReady),
                .csaSum   (csaSum),
                .csaCarry (csaCarry),
                .outValid (outValid),
                .outReady (outReady),
                .product  (product)
        );

endmodule

// ==== carryPropagate.sv ====
`include "multiplier_defines.svh"

module carryPropagate (
        input  logic                    clk,
        input  logic                    reset,
        input  logic                    csaValid,
        output logic                    csaReady,
        input  multiplierPkg::csaWord_t csaSum,
        input  multiplierPkg::csaWord_t csaCarry,
        output logic                    outValid,
        input  logic                    outReady,
        output multiplierPkg::product_t product
);

        import multiplierPkg::*;

        csaWord_t alignedCarry;
        product_t rippleSum;
        logic     carryBit;

        ////////////////////////////////////////////////////////////////////////////
        // ripple carry-propagate adder
        ////////////////////////////////////////////////////////////////////////////

        // carry word moves to its true weight first.
        always_comb begin
                alignedCarry = csaCarry << 1;
                carryBit     = 1'b0;
                for (int i = 0; i < `PRODUCT_WIDTH; i++) begin
                        rippleSum[i] = csaSum[i] ^ alignedCarry[i] ^ carryBit;
                        carryBit     = (csaSum[i] & alignedCarry[i]) |
                                       (carryBit & (csaSum[i] ^ alignedCarry[i]));
                end
        end

        // carry out of the top bit is dropped.

        assign csaReady = !outValid || outReady;

        always_ff @(posedge clk) begin
                if (reset) begin
                        outValid <= 1'b0;
                end else if (csaReady) begin
                        outValid <= csaValid;
                end
        end

        always_ff @(posedge clk) begin
                if (csaValid && csaReady) begin
                        product <= rippleSum;
                end
        end

endmodule

// ==== carrySaveArray.sv ====
`include "multiplier_defines.svh"

module carrySaveArray (
        input  logic                    clk,
        input  logic                    reset,
        input  logic                    ppValid,
        output logic                    ppReady,
        input  multiplierPkg::ppRow_t   ppRows [`PP_ROWS],
        output logic                    csaValid,
        input  logic                    csaReady,
        output multiplierPkg::csaWord_t csaSum,
        output multiplierPkg::csaWord_t csaCarry
);

        import multiplierPkg::*;

        // running redundant pair, carry held unshifted.
        csaWord_t sumVec;
        csaWord_t carryVec;

        // per-row temporaries.
        csaWord_t shiftedCarry;
        csaWord_t rowCarry;

        ////////////////////////////////////////////////////////////////////////////
        // carry-save reduction
        ////////////////////////////////////////////////////////////////////////////

        // one full-adder row per partial product.
        // first row sees a zero carry, so it acts as half adders.
        always_comb begin
                sumVec   = ppRows[0];
                carryVec = '0;
                for (int k = 1; k < `PP_ROWS; k++) begin
                        shiftedCarry = carryVec << 1;

                        // majority of the three inputs.
                        rowCarry = (sumVec & shiftedCarry) |
                                   (sumVec & ppRows[k]) |
                                   (shiftedCarry & ppRows[k]);

                        sumVec   = sumVec ^ shiftedCarry ^ ppRows[k];
                        carryVec = rowCarry;
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // stage register
        ////////////////////////////////////////////////////////////////////////////

        assign ppReady = !csaValid || csaReady;

        always_ff @(posedge clk) begin
                if (reset) begin
                        csaValid <= 1'b0;
                end else if (ppReady) begin
                        csaValid <= ppValid;
                end
        end

        // redundant pair, resolved in the next stage.
        always_ff @(posedge clk) begin
                if (ppValid && ppReady) begin
                        csaSum   <= sumVec;
                        csaCarry <= carryVec;
                end
        end

endmodule

// ==== partialProductGen.sv ====
`include "multiplier_defines.svh"

module partialProductGen (
        input  logic                   clk,
        input  logic                   reset,
        input  logic                   inValid,
        output logic                   inReady,
        input  multiplierPkg::operand_t multiplicand,
        input  multiplierPkg::operand_t multiplier,
        input  logic                   isSigned,
        output logic                   ppValid,
        input  logic                   ppReady,
        output multiplierPkg::ppRow_t  ppRows [`PP_ROWS]
);

        import multiplierPkg::*;

        operand_t rowBits;
        ppRow_t   nextRows [`PP_ROWS];

        ////////////////////////////////////////////////////////////////////////////
        // partial products
        ////////////////////////////////////////////////////////////////////////////

        // baugh-wooley, terms with exactly one sign bit get inverted.
        always_comb begin
                for (int i = 0; i < `OPERAND_WIDTH; i++) begin
                        rowBits = multiplicand & {`OPERAND_WIDTH{multiplier[i]}};
                        if (isSigned) begin
                                if (i == `OPERAND_WIDTH - 1) begin
                                        rowBits[`OPERAND_WIDTH-2:0] = ~rowBits[`OPERAND_WIDTH-2:0];
                                end else begin
                                        rowBits[`OPERAND_WIDTH-1] = ~rowBits[`OPERAND_WIDTH-1];
                                end
                        end
                        nextRows[i] = ppRow_t'(rowBits) << i;
                end

                // correction constant 2^16 + 2^31.
                if (isSigned) begin
                        nextRows[`PP_ROWS-1] = (ppRow_t'(1) << `OPERAND_WIDTH) |
                                               (ppRow_t'(1) << (`PRODUCT_WIDTH - 1));
                end else begin
                        nextRows[`PP_ROWS-1] = '0;
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // stage register
        ////////////////////////////////////////////////////////////////////////////

        assign inReady = !ppValid || ppReady;

        always_ff @(posedge clk) begin
                if (reset) begin
                        ppValid <= 1'b0;
                end else if (inReady) begin
                        ppValid <= inValid;
                end
        end

        always_ff @(posedge clk) begin
                if (inValid && inReady) begin
                        ppRows <= nextRows;
                end
        end

endmodule

// ==== multiplierPkg.sv ====
`include "multiplier_defines.svh"

package multiplierPkg;

        // multiplicand or multiplier.
        typedef logic [`OPERAND_WIDTH-1:0] operand_t;

        // full width product.
        typedef logic [`PRODUCT_WIDTH-1:0] product_t;

        // one partial-product row, already at its weight.
        typedef logic [`PRODUCT_WIDTH-1:0] ppRow_t;

        // redundant sum or carry word out of the array.
        // carry words are kept unshifted, weight is one bit higher.
        typedef logic [`PRODUCT_WIDTH-1:0] csaWord_t;

endpackage

// ==== multiplier_defines.svh ====
`ifndef MULTIPLIER_DEFINES_SVH
`define MULTIPLIER_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// multiplier geometry
////////////////////////////////////////////////////////////////////////////

// width of each operand.
`define OPERAND_WIDTH 16

// full product, twice the operand width.
`define PRODUCT_WIDTH 32

// one row per multiplier bit plus the correction row.
`define PP_ROWS 17

`endif
